// File: flist.f
source/cpu_pkg.sv
source/ctrl_if.sv
source/sync_memory.sv
source/instr_fetch.sv
source/control_unit.sv
source/register_bank.sv
source/alu.sv
source/branch_condition.sv
source/processor.sv
verif/processor_checker.sv
verif/processor_tb.sv

// File: verif/processor_tb.sv
module processor_tb;
	timeunit 1ns;
	timeprecision 1ns;
	import cpu_pkg::*;

	localparam int NUM_TESTS = 8;
	localparam int PROLOGUE  = 15;  // Seven ADDIs, then stores to data addresses 0 to 7.

	logic        CLK;
	logic        rst;
	logic        load_en;
	addr_t       load_addr;
	word_t       load_data;
	logic        start;
	logic        wb_valid;
	reg_idx_t    wb_reg;
	word_t       wb_data;
	logic        store_valid;
	addr_t       store_addr;
	word_t       store_data;
	flags_t      flags;
	logic        halted;
	logic        busy;
	int          tests_done;
	int          events_checked;
	int          error_count;
	logic [31:0] rng_state;
	word_t       programs [$];
	int          prog_len [NUM_TESTS];
	int          prog_base [NUM_TESTS];
	bit          programs_ready;

	processor processor_inst (.*);

	processor_checker scoreboard (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program generation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] random_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic word_t encode(input logic [3:0] op, input reg_idx_t rd,
			input reg_idx_t ra, input reg_idx_t rb, input logic [2:0] cond,
			input logic [15:0] imm);
		return {op, rd, ra, rb, cond, imm};
	endfunction

	function automatic word_t random_instr(input int idx, input int last);
		logic [31:0] r;
		logic [31:0] s;
		logic [3:0]  op;
		logic [15:0] imm;
		reg_idx_t    ra;
		r   = random_word();
		s   = random_word();
		op  = 4'(r % 12);
		ra  = r[9:7];
		imm = s[15:0];
		case (op)
			OP_LOAD: begin
				ra  = 3'd0;
				imm = 16'(s % 8);
			end
			OP_STORE: imm = {{12{s[3]}}, s[3:0]};  // Small signed offset from any register.
			OP_BR:    imm = 16'(s % (last - idx));  // Forward, at most onto the HALT.
			OP_JAL: begin
				ra  = 3'd0;
				imm = 16'(idx + 1 + s % (last - idx));
			end
			default: ;
		endcase
		return encode(op, r[6:4], ra, r[12:10], r[15:13], imm);
	endfunction

	task automatic build_programs();
		int len;
		for (int t = 0; t < NUM_TESTS; t++) begin
			len          = PROLOGUE + 25 + int'(random_word() % 24);
			prog_len[t]  = len;
			prog_base[t] = programs.size();
			for (int r = 1; r < NUM_REGS; r++) begin
				programs.push_back(encode(OP_ADDI, reg_idx_t'(r), 3'd0, 3'd0, 3'd0,
					16'(random_word())));
			end
			for (int k = 0; k < 8; k++) begin
				programs.push_back(encode(OP_STORE, 3'd0, 3'd0,
					reg_idx_t'(1 + random_word() % 7), 3'd0, 16'(k)));
			end
			for (int i = PROLOGUE; i < len - 1; i++) begin
				programs.push_back(random_instr(i, len - 1));
			end
			programs.push_back(encode(4'(int'(OP_HALT) + random_word() % 4), 3'd0, 3'd0,
				3'd0, 3'd0, 16'd0));  // Codes 12 to 15 all halt.
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_test(input int t);
		@(posedge CLK);
		rst <= 1'b1;
		repeat (8) @(posedge CLK);
		rst <= 1'b0;
		for (int i = 0; i < prog_len[t]; i++) begin
			load_en   <= 1'b1;
			load_addr <= addr_t'(i);
			load_data <= programs[prog_base[t] + i];
			@(posedge CLK);
		end
		load_en <= 1'b0;
		start   <= 1'b1;
		@(posedge CLK);
		start <= 1'b0;
		while (!halted) @(posedge CLK);
		repeat (8) @(posedge CLK);  // The checker watches the quiet cycles after HALT.
	endtask

	initial begin
		int limit;
		wait (programs_ready);
		limit = 200;
		for (int t = 0; t < NUM_TESTS; t++) begin
			limit += 5 * prog_len[t] + 30;  // Load, reset and four cycles per instruction.
		end
		repeat (limit) @(posedge CLK);
		$display("Timeout: the processor never halted within %0d cycles.", limit);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst       = 1'b1;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		start     = 1'b0;
		rng_state = 32'h50fdd0ff;
		build_programs();
		programs_ready = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d events checked, %0d errors",
			tests_done, events_checked, error_count);
		if (error_count == 0 && tests_done == NUM_TESTS) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: verif/processor_checker.sv
module processor_checker (
	input  logic              CLK,
	input  logic              rst,
	input  logic              load_en,
	input  cpu_pkg::addr_t    load_addr,
	input  cpu_pkg::word_t    load_data,
	input  logic              start,
	input  logic              wb_valid,
	input  cpu_pkg::reg_idx_t wb_reg,
	input  cpu_pkg::word_t    wb_data,
	input  logic              store_valid,
	input  cpu_pkg::addr_t    store_addr,
	input  cpu_pkg::word_t    store_data,
	input  cpu_pkg::flags_t   flags,
	input  logic              halted,
	input  logic              busy,
	output int                tests_done,
	output int                events_checked,
	output int                error_count
);
	timeunit 1ns;
	timeprecision 1ns;
	import cpu_pkg::*;

	word_t    imem_model [IMEM_DEPTH];
	word_t    dmem_model [DMEM_DEPTH];
	word_t    regs_model [NUM_REGS];
	flags_t   flags_model;
	addr_t    pc_model;
	logic     running;
	logic     after_halt;
	int       run_cycle;
	int       post_cycles;
	int       executed;
	int       test_errors;
	logic     exp_wb;
	logic     exp_store;
	logic     exp_halt;
	reg_idx_t exp_reg;
	word_t    exp_wb_data;
	addr_t    exp_store_addr;
	word_t    exp_store_data;

	initial begin
		tests_done     = 0;
		events_checked = 0;
		error_count    = 0;
		running        = 1'b0;
		after_halt     = 1'b0;
	end

	task automatic report_value(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic protocol_fault(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction-set model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic compute_alu(input logic [3:0] op, input word_t a, input word_t b,
			output word_t r, output flags_t f);
		longint sa;
		longint sb;
		longint sr;
		int     sh;
		logic   c;
		sa = $signed(a);
		sb = $signed(b);
		sr = 0;
		sh = b[4:0];
		c  = 1'b0;
		case (op)
			OP_ADD, OP_ADDI: begin
				r  = a + b;
				c  = (r < a);  // Wrapped around, so a carry left bit 31.
				sr = sa + sb;
			end
			OP_SUB: begin
				r  = a - b;
				c  = (a >= b);
				sr = sa - sb;
			end
			OP_AND: r = a & b;
			OP_OR:  r = a | b;
			OP_XOR: r = a ^ b;
			OP_SHL: begin
				r = a << sh;
				c = (sh == 0) ? 1'b0 : a[32 - sh];
			end
			OP_SHR: begin
				r = a >> sh;
				c = (sh == 0) ? 1'b0 : a[sh - 1];
			end
			default: r = '0;
		endcase
		f.o = (op inside {OP_ADD, OP_ADDI, OP_SUB}) && (sr != longint'($signed(r)));
		f.s = r[31];
		f.c = c;
		f.z = (r == '0);
	endtask

	function automatic logic cond_holds(input logic [2:0] cond, input flags_t f);
		case (cond)
			COND_ALWAYS: return 1'b1;
			COND_EQ:     return f.z;
			COND_NE:     return !f.z;
			COND_NEG:    return f.s;
			COND_POS:    return !f.s;
			COND_CARRY:  return f.c;
			COND_OVFL:   return f.o;
			default:     return 1'b0;
		endcase
	endfunction

	task automatic execute_model();
		instr_t ins;
		word_t  a;
		word_t  b;
		word_t  imm_ext;
		word_t  value;
		flags_t f;
		addr_t  addr;
		addr_t  next_pc;
		logic   writes;
		ins       = instr_t'(imem_model[pc_model]);
		a         = (ins.ra == 0) ? '0 : regs_model[ins.ra];
		b         = (ins.rb == 0) ? '0 : regs_model[ins.rb];
		imm_ext   = {{16{ins.imm[15]}}, ins.imm};
		addr      = a[7:0] + imm_ext[7:0];
		next_pc   = pc_model + 8'd1;
		value     = '0;
		writes    = 1'b0;
		exp_wb    = 1'b0;
		exp_store = 1'b0;
		exp_halt  = 1'b0;
		case (ins.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_ADDI: begin
				compute_alu(ins.opcode, a, (ins.opcode == OP_ADDI) ? imm_ext : b, value, f);
				flags_model = f;
				writes      = 1'b1;
			end
			OP_LOAD: begin
				value  = dmem_model[addr];
				writes = 1'b1;
			end
			OP_STORE: begin
				dmem_model[addr] = b;
				exp_store        = 1'b1;
				exp_store_addr   = addr;
				exp_store_data   = b;
			end
			OP_BR: if (cond_holds(ins.cond, flags_model)) next_pc = pc_model + 8'd1 + imm_ext[7:0];
			OP_JAL: begin
				value   = {24'b0, pc_model + 8'd1};
				next_pc = addr;
				writes  = 1'b1;
			end
			default: exp_halt = 1'b1;
		endcase
		if (writes && ins.rd != 0) begin
			regs_model[ins.rd] = value;
			exp_wb             = 1'b1;
			exp_reg            = ins.rd;
			exp_wb_data        = value;
		end
		pc_model = next_pc;
		executed++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cycle-by-cycle comparison
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_store(input logic expected);
		if (expected && !store_valid)
			protocol_fault("a STORE reached EXECUTE without a store event");
		else if (!expected && store_valid)
			protocol_fault("a store event appeared that the program does not make");
		else if (expected) begin
			events_checked++;
			if (store_addr !== exp_store_addr || store_data !== exp_store_data)
				report_value($sformatf("store [%h] = %h, expected [%h] = %h",
					store_addr, store_data, exp_store_addr, exp_store_data));
		end
	endtask

	task automatic check_wb(input logic expected);
		if (expected && !wb_valid)
			protocol_fault("a register write reached WRITEBACK without a write-back event");
		else if (!expected && wb_valid)
			protocol_fault("a write-back event appeared that the program does not make");
		else if (expected) begin
			events_checked++;
			if (wb_reg !== exp_reg || wb_data !== exp_wb_data)
				report_value($sformatf("r%0d <= %h, expected r%0d <= %h",
					wb_reg, wb_data, exp_reg, exp_wb_data));
		end
	endtask

	task automatic check_cycle();
		int phase;
		run_cycle++;
		phase = (run_cycle - 1) % 4;  // FETCH is phase 0 of every instruction.
		if (phase == 0 && exp_halt) begin
			if (!halted)
				protocol_fault("halted did not rise in the cycle after HALT reached WRITEBACK");
			events_checked++;
			if (flags !== flags_model)
				report_value($sformatf("final flags %b, expected %b", flags, flags_model));
			running     = 1'b0;
			after_halt  = 1'b1;
			post_cycles = 0;
		end else begin
			if (phase == 0) begin
				if (flags !== flags_model)
					report_value($sformatf("flags %b after %0d instructions, expected %b",
						flags, executed, flags_model));
				execute_model();
			end
			if (halted || !busy)
				protocol_fault("halted or busy changed before the program reached HALT");
			check_store(phase == 2 && exp_store);
			check_wb(phase == 3 && exp_wb);
		end
	endtask

	task automatic check_quiet();
		post_cycles++;
		if (wb_valid || store_valid)
			protocol_fault("an event appeared after the processor halted");
		if (!halted || busy)
			protocol_fault("halted fell or busy rose after the processor halted");
		if (post_cycles == 4) begin
			$display("Test %0d %s: %0d instructions executed, %0d errors", tests_done + 1,
				(test_errors == 0) ? "passed" : "FAILED", executed, test_errors);
			tests_done++;
			after_halt = 1'b0;
		end
	endtask

	// Sampled on the falling edge, when inputs and outputs are settled.
	always @(negedge CLK) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_model[i] = '0;
			end
			flags_model = '0;
			running     = 1'b0;
			after_halt  = 1'b0;
		end else begin
			if (load_en && !busy)
				imem_model[load_addr] = load_data;
			if (running)
				check_cycle();
			else if (after_halt)
				check_quiet();
			else if (start && !busy && !halted) begin
				running     = 1'b1;
				run_cycle   = 0;
				pc_model    = '0;
				executed    = 0;
				test_errors = 0;
				exp_wb      = 1'b0;
				exp_store   = 1'b0;
				exp_halt    = 1'b0;
			end
		end
	end

endmodule

// File: source/processor.sv
module processor (
	input  logic              CLK,
	input  logic              rst,
	input  logic              load_en,
	input  cpu_pkg::addr_t    load_addr,
	input  cpu_pkg::word_t    load_data,
	input  logic              start,
	output logic              wb_valid,
	output cpu_pkg::reg_idx_t wb_reg,
	output cpu_pkg::word_t    wb_data,
	output logic              store_valid,
	output cpu_pkg::addr_t    store_addr,
	output cpu_pkg::word_t    store_data,
	output cpu_pkg::flags_t   flags,
	output logic              halted,
	output logic              busy
);
	import cpu_pkg::*;

	ctrl_if ctrl_bus ();

	instr_t instr;
	addr_t  pc;
	addr_t  link_pc;
	addr_t  mem_addr;
	word_t  rdata_a;
	word_t  rdata_b;
	word_t  imm_ext;
	word_t  alu_b;
	word_t  alu_result;
	word_t  dmem_rdata;
	word_t  wb_value;
	flags_t alu_flags;
	logic   branch_taken;
	logic   load_ok;
	logic   start_ok;

	assign load_ok  = load_en && !busy;  // Program loads only between runs.
	assign start_ok = start && !busy;

	instr_fetch fetch (
		.CLK(CLK), .rst(rst), .start(start_ok),
		.load_en(load_ok), .load_addr(load_addr), .load_data(load_data),
		.target_base(rdata_a), .branch_taken(branch_taken),
		.ctrl(ctrl_bus.dp), .instr(instr), .pc(pc)
	);

	control_unit control (
		.CLK(CLK), .rst(rst), .start(start), .instr(instr),
		.busy(busy), .halted(halted), .ctrl(ctrl_bus.ctrl)
	);

	register_bank regs (
		.CLK(CLK), .rst(rst), .ra(instr.ra), .rb(instr.rb), .rd(instr.rd),
		.wdata(wb_value), .ctrl(ctrl_bus.dp), .rdata_a(rdata_a), .rdata_b(rdata_b)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute and data memory
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign imm_ext = {{16{instr.imm[15]}}, instr.imm};
	assign alu_b   = ctrl_bus.use_imm ? imm_ext : rdata_b;

	alu exec (
		.a(rdata_a), .b(alu_b), .ctrl(ctrl_bus.dp),
		.result(alu_result), .alu_flags(alu_flags)
	);

	branch_condition cond_test (
		.CLK(CLK), .rst(rst), .alu_flags(alu_flags), .cond(instr.cond),
		.ctrl(ctrl_bus.dp), .flags(flags), .branch_taken(branch_taken)
	);

	assign mem_addr = addr_t'(alu_result);

	sync_memory #(
		.word_type(word_t),
		.DEPTH    (DMEM_DEPTH)
	) dmem (
		.CLK(CLK), .we(ctrl_bus.mem_we), .addr(mem_addr),
		.wdata(rdata_b), .rdata(dmem_rdata)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write-back and observation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign link_pc = pc + 8'd1;

	always_comb begin
		case (ctrl_bus.wb_sel)
			WB_MEM:  wb_value = dmem_rdata;  // Read issued in EXECUTE.
			WB_LINK: wb_value = word_t'(link_pc);
			default: wb_value = alu_result;
		endcase
	end

	assign wb_valid    = ctrl_bus.reg_we && (instr.rd != '0);
	assign wb_reg      = instr.rd;
	assign wb_data     = wb_value;
	assign store_valid = ctrl_bus.mem_we;
	assign store_addr  = mem_addr;
	assign store_data  = rdata_b;

endmodule

// File: source/branch_condition.sv
module branch_condition (
	input  logic            CLK,
	input  logic            rst,
	input  cpu_pkg::flags_t alu_flags,
	input  cpu_pkg::cond_e  cond,
	ctrl_if.dp              ctrl,
	output cpu_pkg::flags_t flags,
	output logic            branch_taken
);
	import cpu_pkg::*;

	logic cond_ok;

	always_ff @(posedge CLK) begin
		if (rst)
			flags <= '0;
		else if (ctrl.flag_we)
			flags <= alu_flags;
	end

	always_comb begin
		unique case (cond)
			COND_ALWAYS: cond_ok = 1'b1;
			COND_EQ:     cond_ok = flags.z;
			COND_NE:     cond_ok = !flags.z;
			COND_NEG:    cond_ok = flags.s;
			COND_POS:    cond_ok = !flags.s;
			COND_CARRY:  cond_ok = flags.c;
			COND_OVFL:   cond_ok = flags.o;
			default:     cond_ok = 1'b0;  // NEVER.
		endcase
	end

	assign branch_taken = ctrl.take_branch_ok && cond_ok;

	assert property (@(posedge CLK) disable iff (rst)
		!ctrl.flag_we |=> $stable(flags));

endmodule

// File: source/alu.sv
module alu (
	input  cpu_pkg::word_t  a,
	input  cpu_pkg::word_t  b,
	ctrl_if.dp              ctrl,
	output cpu_pkg::word_t  result,
	output cpu_pkg::flags_t alu_flags
);
	import cpu_pkg::*;

	logic       carry;
	logic       ovfl;
	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		carry = 1'b0;
		ovfl  = 1'b0;
		case (ctrl.alu_op)
			ALU_ADD: begin
				{carry, result} = {1'b0, a} + {1'b0, b};
				ovfl = (a[31] == b[31]) && (result[31] != a[31]);
			end
			ALU_SUB: begin
				{carry, result} = {1'b0, a} + {1'b0, ~b} + 33'd1;  // Carry set means no borrow.
				ovfl = (a[31] != b[31]) && (result[31] != a[31]);
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SHL: {carry, result} = {1'b0, a} << shamt;  // Last bit out lands in carry.
			ALU_SHR: {result, carry} = {a, 1'b0} >> shamt;
			default: result = '0;
		endcase
	end

	assign alu_flags = '{
		o: ovfl,
		s: result[31],
		c: carry,
		z: (result == '0)
	};

endmodule

// File: source/register_bank.sv
module register_bank (
	input  logic             CLK,
	input  logic             rst,
	input  cpu_pkg::reg_idx_t ra,
	input  cpu_pkg::reg_idx_t rb,
	input  cpu_pkg::reg_idx_t rd,
	input  cpu_pkg::word_t   wdata,
	ctrl_if.dp               ctrl,
	output cpu_pkg::word_t   rdata_a,
	output cpu_pkg::word_t   rdata_b
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.reg_we && (rd != '0)) begin
			regs[rd] <= wdata;  // Writes to r0 are dropped.
		end
	end

	// Reads are combinational so DECODE sees the operands at once.
	assign rdata_a = (ra == '0) ? '0 : regs[ra];
	assign rdata_b = (rb == '0) ? '0 : regs[rb];

endmodule

// File: source/control_unit.sv
module control_unit (
	input  logic            CLK,
	input  logic            rst,
	input  logic            start,
	input  cpu_pkg::instr_t instr,
	output logic            busy,
	output logic            halted,
	ctrl_if.ctrl            ctrl
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, S_FETCH, S_DECODE, S_EXECUTE, S_WRITEBACK, S_HALTED
	} state_e;

	state_e  state;
	state_e  state_next;
	logic    wr_reg;
	logic    wr_flags;
	logic    is_store;
	logic    is_branch;
	logic    is_halt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_next = state;
		unique case (state)
			S_IDLE:      if (start) state_next = S_FETCH;
			S_FETCH:     state_next = S_DECODE;
			S_DECODE:    state_next = S_EXECUTE;
			S_EXECUTE:   state_next = S_WRITEBACK;
			S_WRITEBACK: state_next = is_halt ? S_HALTED : S_FETCH;
			default:     state_next = S_HALTED;  // Only reset leaves here.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst)
			state <= S_IDLE;
		else
			state <= state_next;
	end

	assign busy   = (state != S_IDLE) && (state != S_HALTED);
	assign halted = (state == S_HALTED);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decoder
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		ctrl.alu_op  = ALU_ADD;  // Loads and stores add ra and imm.
		ctrl.use_imm = 1'b0;
		ctrl.wb_sel  = WB_ALU;
		ctrl.jump    = 1'b0;
		wr_reg       = 1'b0;
		wr_flags     = 1'b0;
		is_store     = 1'b0;
		is_branch    = 1'b0;
		is_halt      = 1'b0;
		case (instr.opcode)
			OP_ADD, OP_ADDI: begin
				ctrl.use_imm = (instr.opcode == OP_ADDI);
				wr_reg       = 1'b1;
				wr_flags     = 1'b1;
			end
			OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR: begin
				ctrl.alu_op = alu_op_e'(instr.opcode);  // Codes line up with the ALU ones.
				wr_reg      = 1'b1;
				wr_flags    = 1'b1;
			end
			OP_LOAD: begin
				ctrl.use_imm = 1'b1;
				ctrl.wb_sel  = WB_MEM;
				wr_reg       = 1'b1;
			end
			OP_STORE: begin
				ctrl.use_imm = 1'b1;
				is_store     = 1'b1;
			end
			OP_BR: is_branch = 1'b1;
			OP_JAL: begin
				ctrl.jump   = 1'b1;
				ctrl.wb_sel = WB_LINK;
				wr_reg      = 1'b1;
			end
			default: is_halt = 1'b1;
		endcase
	end

	assign ctrl.reg_we         = (state == S_WRITEBACK) && wr_reg;
	assign ctrl.flag_we        = (state == S_WRITEBACK) && wr_flags;
	assign ctrl.pc_we          = (state == S_WRITEBACK) && !is_halt;
	assign ctrl.take_branch_ok = (state == S_WRITEBACK) && is_branch;
	assign ctrl.mem_we         = (state == S_EXECUTE) && is_store;

	// Each strobe sits at a fixed distance from the FETCH of its instruction.
	assert property (@(posedge CLK) disable iff (rst)
		(ctrl.reg_we || ctrl.pc_we) |-> $past(state, 3) == S_FETCH);
	assert property (@(posedge CLK) disable iff (rst)
		ctrl.mem_we |-> $past(state, 2) == S_FETCH);
	assert property (@(posedge CLK) disable iff (rst)
		state == S_HALTED |=> state == S_HALTED);

endmodule

// File: source/instr_fetch.sv
module instr_fetch (
	input  logic            CLK,
	input  logic            rst,
	input  logic            start,
	input  logic            load_en,
	input  cpu_pkg::addr_t  load_addr,
	input  cpu_pkg::word_t  load_data,
	input  cpu_pkg::word_t  target_base,
	input  logic            branch_taken,
	ctrl_if.dp              ctrl,
	output cpu_pkg::instr_t instr,
	output cpu_pkg::addr_t  pc
);
	import cpu_pkg::*;

	addr_t pc_plus1;
	addr_t branch_target;
	addr_t jump_target;
	addr_t pc_next;
	addr_t imem_addr;

	assign pc_plus1      = pc + 8'd1;
	assign branch_target = pc_plus1 + addr_t'(instr.imm);  // Wraps modulo 256.
	assign jump_target   = addr_t'(target_base) + addr_t'(instr.imm);

	always_comb begin
		if (ctrl.jump)
			pc_next = jump_target;
		else if (branch_taken)
			pc_next = branch_target;
		else
			pc_next = pc_plus1;
	end

	always_ff @(posedge CLK) begin
		if (rst || start)
			pc <= '0;
		else if (ctrl.pc_we)
			pc <= pc_next;
	end

	assign imem_addr = load_en ? load_addr : pc;  // Load port wins only when idle.

	sync_memory #(
		.word_type(instr_t),
		.DEPTH    (IMEM_DEPTH)
	) imem (
		.CLK  (CLK),
		.we   (load_en),
		.addr (imem_addr),
		.wdata(instr_t'(load_data)),
		.rdata(instr)
	);

endmodule

// File: source/sync_memory.sv
module sync_memory #(
	parameter type word_type = cpu_pkg::word_t,
	parameter int  DEPTH     = cpu_pkg::DMEM_DEPTH
) (
	input  logic           CLK,
	input  logic           we,
	input  cpu_pkg::addr_t addr,
	input  word_type       wdata,
	output word_type       rdata
);

	word_type mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];  // A write in the same cycle reads back the old word.
	end

endmodule

// File: source/ctrl_if.sv
interface ctrl_if;
	import cpu_pkg::*;

	alu_op_e alu_op;
	logic    use_imm;         // Second operand is the sign-extended imm.
	logic    reg_we;
	logic    flag_we;
	logic    mem_we;
	logic    pc_we;
	logic    take_branch_ok;  // Lets the condition test move the PC.
	logic    jump;
	wb_sel_e wb_sel;

	modport ctrl (
		output alu_op, use_imm,
		output reg_we, flag_we, mem_we, pc_we,
		output take_branch_ok, jump, wb_sel
	);

	modport dp (
		input alu_op, use_imm,
		input reg_we, flag_we, mem_we, pc_we,
		input take_branch_ok, jump, wb_sel
	);

endinterface

// File: source/cpu_pkg.sv
package cpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int WORD_W     = 32;
	localparam int NUM_REGS   = 8;
	localparam int ADDR_W     = 8;
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [2:0]        reg_idx_t;
	typedef logic [ADDR_W-1:0] addr_t;  // Addresses both memories.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction format
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_ADDI,
		OP_LOAD, OP_STORE, OP_BR, OP_JAL, OP_HALT  // Codes 13 to 15 also halt.
	} opcode_e;

	typedef enum logic [2:0] {
		COND_ALWAYS, COND_EQ, COND_NE, COND_NEG,
		COND_POS, COND_CARRY, COND_OVFL, COND_NEVER
	} cond_e;

	typedef struct packed {
		opcode_e            opcode;  // Bits 31 to 28.
		reg_idx_t           rd;
		reg_idx_t           ra;
		reg_idx_t           rb;
		cond_e              cond;
		logic signed [15:0] imm;
	} instr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execution
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR
	} alu_op_e;

	typedef struct packed {
		logic o;
		logic s;
		logic c;  // Carry out, or no borrow on subtract.
		logic z;
	} flags_t;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_LINK
	} wb_sel_e;

endpackage
